/* common/roll_display_pkg.sv */
`default_nettype none

package roll_display_pkg;

	localparam int DIGIT_W  = 4;
	localparam int EFFECT_W = 5;
	localparam int LFSR_W   = 16;

	// an all-zero LFSR would lock up
	localparam logic [LFSR_W-1:0] LFSR_SEED = {LFSR_W{1'b1}};

	// what the output side does this cycle
	typedef enum logic [1:0] {
		OP_HOLD,
		OP_DRAW,
		OP_EFFECT_STEP,
		OP_EFFECT_CLEAR
	} draw_op_e;

	// command word from control to output
	typedef struct packed {
		draw_op_e op;
	} draw_cmd_t;

endpackage

`default_nettype wire

/* common/roll_timing_pkg.sv */
`default_nettype none

package roll_timing_pkg;

	// control state of the roller
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_RUN,
		ST_PAUSE,
		ST_FINISHED
	} ctrl_state_e;

	// tempo level, 1 is slowest and 7 is fastest
	localparam int TEMPO_W = 3;

	typedef logic [TEMPO_W-1:0] tempo_t;

	localparam tempo_t TEMPO_START = 3'd5;
	localparam tempo_t TEMPO_TOP   = 3'd7;

	localparam int TICK_W      = 16;
	localparam int DIGIT_CNT_W = 5;

	// cycles between draws, index is the tempo level
	localparam logic [7:1][TICK_W-1:0] TICK_LIMIT = {
		16'd50,
		16'd500,
		16'd1000,
		16'd2500,
		16'd5000,
		16'd5000,
		16'd7500
	};

	// draws before dropping one level
	localparam logic [7:1][DIGIT_CNT_W-1:0] DIGIT_LIMIT = {
		5'd30,
		5'd15,
		5'd7,
		5'd5,
		5'd3,
		5'd2,
		5'd2
	};

	// finish effect pacing
	localparam logic [TICK_W-1:0]      FINISH_TICK_LIMIT = 16'd500;
	localparam logic [DIGIT_CNT_W-1:0] EFFECT_STEPS      = 5'd20;

endpackage

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# build the roller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module roll_tb -f tb.f -o roll_sim
./obj_dir/roll_sim | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb.f */
+incdir+testbench
common/roll_timing_pkg.sv
common/roll_display_pkg.sv
verilog/key_pulse.sv
tempo_ctrl/tempo_ctrl.sv
verilog/digit_draw.sv
verilog/roll_top.sv
testbench/roll_tb.sv

/* tempo_ctrl/tempo_ctrl.sv */
`default_nettype none

module tempo_ctrl (
	input  logic                          i_clk,
	input  logic                          i_rst_n,
	input  logic                          i_start_p,
	input  logic                          i_pause_p,
	input  logic                          i_speedup_p,
	output roll_display_pkg::draw_cmd_t   o_cmd
);

	import roll_timing_pkg::*;
	import roll_display_pkg::*;

	ctrl_state_e             state_r;
	ctrl_state_e             state_n;
	tempo_t                  level_r;
	tempo_t                  level_n;
	logic [TICK_W-1:0]       tick_r;
	logic [TICK_W-1:0]       tick_n;
	// digit count while rolling, effect steps once finished
	logic [DIGIT_CNT_W-1:0]  cnt_r;
	logic [DIGIT_CNT_W-1:0]  cnt_n;
	draw_cmd_t               cmd_r;
	draw_cmd_t               cmd_n;

	logic tick_hit;
	logic level_done;
	logic finish_hit;
	logic effect_done;

	assign tick_hit    = tick_r > TICK_LIMIT[level_r];
	assign level_done  = cnt_r >= DIGIT_LIMIT[level_r];
	assign finish_hit  = tick_r > FINISH_TICK_LIMIT;
	assign effect_done = cnt_r >= EFFECT_STEPS;

	always_comb begin
		state_n    = state_r;
		level_n    = level_r;
		tick_n     = tick_r;
		cnt_n      = cnt_r;
		cmd_n.op   = OP_HOLD;

		case (state_r)
			ST_IDLE: begin
				if (i_start_p) begin
					state_n  = ST_RUN;
					level_n  = TEMPO_START;
					tick_n   = '0;
					cnt_n    = '0;
					cmd_n.op = OP_DRAW;
				end
			end

			ST_RUN: begin
				if (i_pause_p) begin
					// counters frozen until resume
					state_n = ST_PAUSE;
				end else if (i_speedup_p) begin
					level_n  = TEMPO_TOP;
					tick_n   = '0;
					cnt_n    = '0;
					cmd_n.op = OP_DRAW;
				end else if (tick_hit && level_done) begin
					tick_n = '0;
					cnt_n  = '0;
					if (level_r == 3'd1) begin
						// slowest level done, no last draw
						state_n = ST_FINISHED;
					end else begin
						level_n  = level_r - 1'b1;
						cmd_n.op = OP_DRAW;
					end
				end else if (tick_hit) begin
					tick_n   = '0;
					cnt_n    = cnt_r + 1'b1;
					cmd_n.op = OP_DRAW;
				end else begin
					tick_n = tick_r + 1'b1;
				end
			end

			ST_PAUSE: begin
				if (i_pause_p) begin
					state_n = ST_RUN;
				end else if (i_speedup_p) begin
					// fresh digit but stay paused
					level_n  = TEMPO_TOP;
					tick_n   = '0;
					cnt_n    = '0;
					cmd_n.op = OP_DRAW;
				end
			end

			ST_FINISHED: begin
				if (i_start_p && effect_done) begin
					// restart clears the effect, digit stays until next tick
					state_n  = ST_RUN;
					level_n  = TEMPO_START;
					tick_n   = '0;
					cnt_n    = '0;
					cmd_n.op = OP_EFFECT_CLEAR;
				end else if (finish_hit) begin
					tick_n = '0;
					if (effect_done) begin
						cmd_n.op = OP_EFFECT_CLEAR;
					end else begin
						cnt_n    = cnt_r + 1'b1;
						cmd_n.op = OP_EFFECT_STEP;
					end
				end else begin
					tick_n = tick_r + 1'b1;
				end
			end

			default: begin
				state_n = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state_r  <= ST_IDLE;
			level_r  <= TEMPO_START;
			tick_r   <= '0;
			cnt_r    <= '0;
			cmd_r.op <= OP_HOLD;
		end else begin
			state_r <= state_n;
			level_r <= level_n;
			tick_r  <= tick_n;
			cnt_r   <= cnt_n;
			cmd_r   <= cmd_n;
		end
	end

	assign o_cmd = cmd_r;

endmodule

`default_nettype wire

/* testbench/roll_model.svh */
`ifndef ROLL_MODEL_SVH
`define ROLL_MODEL_SVH

// three cycles from key to pulse, one more from pulse to command
localparam int KEY_TO_CMD = 4;

// next LFSR value, taps 0 2 3 5 shifted in at the top
function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] cur);
	logic fb;
	fb = cur[0] ^ cur[2] ^ cur[3] ^ cur[5];
	return {fb, cur[LFSR_W-1:1]};
endfunction

// the counter has to pass the limit, then one cycle to reload
function automatic int step_cycles();
	return int'(FINISH_TICK_LIMIT) + 2;
endfunction

// limit+1 ticks per level, the last one drops the level
function automatic int level_cycles(input tempo_t level);
	return (int'(DIGIT_LIMIT[level]) + 1) * (int'(TICK_LIMIT[level]) + 2);
endfunction

// key rise to the first effect step, for a roll from the given level down
function automatic int run_cycles(input tempo_t first_level);
	int total;
	total = KEY_TO_CMD + step_cycles();
	for (tempo_t lvl = first_level; lvl != 3'd0; lvl--) begin
		total += level_cycles(lvl);
	end
	return total;
endfunction

`endif

/* testbench/roll_tb.sv */
`default_nettype none

module roll_tb;

	import roll_timing_pkg::*;
	import roll_display_pkg::*;

	`include "roll_model.svh"

	localparam logic [1:0] KEY_START   = 2'd0;
	localparam logic [1:0] KEY_PAUSE   = 2'd1;
	localparam logic [1:0] KEY_SPEEDUP = 2'd2;

	logic                clk = 1'b0;
	logic                rst_n;
	logic [2:0]          keys;
	logic [DIGIT_W-1:0]  digit;
	logic [EFFECT_W-1:0] effect;
	logic [LFSR_W-1:0]   model_lfsr;
	logic [LFSR_W-1:0]   model_prev;
	logic [DIGIT_W-1:0]  last_digit;
	int                  cyc = 0;
	int                  digit_errors = 0;
	int                  seed;
	int                  mismatches;
	int                  timeouts;

	// keys bit 0 start, bit 1 pause, bit 2 speed-up
	roll_top dut0 (
		.i_clk     (clk),
		.i_rst_n   (rst_n),
		.i_start   (keys[0]),
		.i_pause   (keys[1]),
		.i_speedup (keys[2]),
		.o_digit   (digit),
		.o_effect  (effect)
	);

	always #10 clk = ~clk;

	// cycle count and the free-running LFSR copy
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (!rst_n) begin
			model_lfsr <= LFSR_SEED;
			model_prev <= LFSR_SEED;
		end else begin
			model_prev <= model_lfsr;
			model_lfsr <= lfsr_next(model_lfsr);
		end
	end

	// new digit is the LFSR nibble of the cycle before
	always @(negedge clk) begin
		if (rst_n && digit != last_digit) begin
			if (digit != model_prev[DIGIT_W-1:0]) begin
				digit_errors <= digit_errors + 1;
				$display("Mismatch at %0t: digit %0h, LFSR model gives %0h", $time, digit,
					model_prev[DIGIT_W-1:0]);
			end
		end
		last_digit <= digit;
	end

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	// one button press held high for three cycles
	task automatic press_key(input logic [1:0] which, output int at_cyc);
		@(posedge clk);
		#2;
		keys[which] = 1'b1;
		at_cyc = cyc;
		repeat (3) @(posedge clk);
		#2;
		keys[which] = 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk);
	endtask

	task automatic wait_effect_change(input int limit, output int at_cyc);
		logic [EFFECT_W-1:0] from;
		int                  n;
		from = effect;
		n = 0;
		at_cyc = 0;
		while (effect == from && n < limit) begin
			@(negedge clk);
			n++;
		end
		if (effect == from) begin
			timeouts++;
			$display("Timeout at %0t: effect output stayed at %0d for %0d cycles",
				$time, from, limit);
		end else begin
			at_cyc = cyc;
		end
	endtask

	// extra is the number of cycles the roll stood still
	task automatic check_roll(input int key_cyc, input tempo_t level, input int extra,
			output int at_cyc);
		int want;
		want = run_cycles(level) + extra;
		wait_effect_change(want + 100, at_cyc);
		if (effect != 5'd1) begin
			report_mismatch($sformatf("first effect step is %0d, not 1", effect));
		end
		if (at_cyc - key_cyc != want) begin
			report_mismatch($sformatf("roll took %0d cycles, model gives %0d",
				at_cyc - key_cyc, want));
		end
	endtask

	// effect steps and the final clear come one finish tick apart
	task automatic check_effect(input int first_cyc, input bit early_start);
		int prev;
		int at;
		int want;
		int ignored;
		prev = first_cyc;
		for (int step = 2; step <= int'(EFFECT_STEPS) + 1; step++) begin
			if (early_start && step == 6) begin
				press_key(KEY_START, ignored);
			end
			wait_effect_change(step_cycles() + 20, at);
			want = (step > int'(EFFECT_STEPS)) ? 0 : step;
			if (int'(effect) != want) begin
				report_mismatch($sformatf("effect is %0d, expected %0d", effect, want));
			end
			if (at - prev != step_cycles()) begin
				report_mismatch($sformatf("effect step after %0d cycles", at - prev));
			end
			prev = at;
		end
	endtask

	initial begin
		int                 k;
		int                 p;
		int                 q;
		int                 at;
		int                 gap;
		logic [DIGIT_W-1:0] held;
		rst_n = 1'b0;
		keys = 3'b000;
		seed = 32'he802_1001;
		mismatches = 0;
		timeouts = 0;
		repeat (16) @(posedge clk);
		#2;
		rst_n = 1'b1;

		// pause and speed-up do nothing while idle
		press_key(KEY_PAUSE, k);
		press_key(KEY_SPEEDUP, k);
		repeat (2 * (int'(TICK_LIMIT[TEMPO_TOP]) + 2)) begin
			@(negedge clk);
			if (digit !== '0 || effect !== '0) begin
				report_mismatch($sformatf("idle outputs digit %0h effect %0d", digit, effect));
			end
		end

		press_key(KEY_START, k);
		check_roll(k, TEMPO_START, 0, at);
		check_effect(at, 1'b1);

		// roll with a random pause
		press_key(KEY_START, k);
		idle_cycles(20 + int'({$random(seed)} % 3000));
		press_key(KEY_PAUSE, p);
		@(negedge clk);
		held = digit;
		// pause spans more than one draw interval
		gap = int'(TICK_LIMIT[TEMPO_START]) + 2 + int'({$random(seed)} % 500);
		repeat (gap) begin
			@(negedge clk);
			if (digit != held) begin
				report_mismatch($sformatf("digit went %0h to %0h in pause", held, digit));
			end
		end
		press_key(KEY_PAUSE, q);
		// pause and resume cycles also hold the counters
		check_roll(k, TEMPO_START, q - p + 1, at);
		check_effect(at, 1'b0);

		press_key(KEY_START, k);
		idle_cycles(20 + int'({$random(seed)} % 3000));
		press_key(KEY_SPEEDUP, p);
		check_roll(p, TEMPO_TOP, 0, at);
		check_effect(at, 1'b0);

		// speed-up while paused restarts at the top level but stays paused
		press_key(KEY_START, k);
		idle_cycles(20 + int'({$random(seed)} % 3000));
		press_key(KEY_PAUSE, p);
		idle_cycles(10 + int'({$random(seed)} % 300));
		press_key(KEY_SPEEDUP, k);
		idle_cycles(10 + int'({$random(seed)} % 300));
		press_key(KEY_PAUSE, q);
		check_roll(k, TEMPO_TOP, q - k, at);
		check_effect(at, 1'b0);

		$display("done: %0d digit mismatches, %0d other mismatches, %0d timeouts",
			digit_errors, mismatches, timeouts);
		if (digit_errors == 0 && mismatches == 0 && timeouts == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/digit_draw.sv */
`default_nettype none

module digit_draw (
	input  logic                                      i_clk,
	input  logic                                      i_rst_n,
	input  roll_display_pkg::draw_cmd_t               i_cmd,
	output logic [roll_display_pkg::DIGIT_W-1:0]      o_digit,
	output logic [roll_display_pkg::EFFECT_W-1:0]     o_effect
);

	import roll_display_pkg::*;

	logic [LFSR_W-1:0]   lfsr_r;
	logic                lfsr_fb;
	logic [DIGIT_W-1:0]  digit_r;
	logic [EFFECT_W-1:0] effect_r;

	// taps 0, 2, 3, 5 fed back into the top bit
	assign lfsr_fb = lfsr_r[0] ^ lfsr_r[2] ^ lfsr_r[3] ^ lfsr_r[5];

	// free running, also while idle or paused
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			lfsr_r <= LFSR_SEED;
		end else begin
			lfsr_r <= {lfsr_fb, lfsr_r[LFSR_W-1:1]};
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			digit_r  <= '0;
			effect_r <= '0;
		end else begin
			case (i_cmd.op)
				OP_DRAW: begin
					// low nibble of the current LFSR value
					digit_r <= lfsr_r[DIGIT_W-1:0];
				end
				OP_EFFECT_STEP: begin
					effect_r <= effect_r + 1'b1;
				end
				OP_EFFECT_CLEAR: begin
					effect_r <= '0;
				end
				default: begin
					digit_r  <= digit_r;
					effect_r <= effect_r;
				end
			endcase
		end
	end

	assign o_digit  = digit_r;
	assign o_effect = effect_r;

endmodule

`default_nettype wire

/* verilog/key_pulse.sv */
`default_nettype none

module key_pulse (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_start,
	input  logic i_pause,
	input  logic i_speedup,
	output logic o_start_p,
	output logic o_pause_p,
	output logic o_speedup_p
);

	// bit 0 start, bit 1 pause, bit 2 speed-up
	logic [2:0] keys;
	logic [2:0] sync1_r;
	logic [2:0] sync2_r;
	logic [2:0] prev_r;
	logic [2:0] pulse;

	assign keys = {i_speedup, i_pause, i_start};

	// two-flop synchronizer, then one more stage for the edge
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			sync1_r <= 3'b000;
			sync2_r <= 3'b000;
			prev_r  <= 3'b000;
		end else begin
			sync1_r <= keys;
			sync2_r <= sync1_r;
			prev_r  <= sync2_r;
		end
	end

	// rising edge only, so a held key fires once
	assign pulse = sync2_r & ~prev_r;

	assign o_start_p   = pulse[0];
	assign o_pause_p   = pulse[1];
	assign o_speedup_p = pulse[2];

endmodule

`default_nettype wire

/* verilog/roll_top.sv */
`default_nettype none

module roll_top (
	input  logic                                      i_clk,
	input  logic                                      i_rst_n,
	input  logic                                      i_start,
	input  logic                                      i_pause,
	input  logic                                      i_speedup,
	output logic [roll_display_pkg::DIGIT_W-1:0]      o_digit,
	output logic [roll_display_pkg::EFFECT_W-1:0]     o_effect
);

	import roll_display_pkg::*;

	logic      start_p;
	logic      pause_p;
	logic      speedup_p;
	draw_cmd_t cmd;

	// board keys to one-cycle pulses
	key_pulse u_key_pulse (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start     (i_start),
		.i_pause     (i_pause),
		.i_speedup   (i_speedup),
		.o_start_p   (start_p),
		.o_pause_p   (pause_p),
		.o_speedup_p (speedup_p)
	);

	tempo_ctrl u_tempo_ctrl (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_start_p   (start_p),
		.i_pause_p   (pause_p),
		.i_speedup_p (speedup_p),
		.o_cmd       (cmd)
	);

	digit_draw u_digit_draw (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_cmd    (cmd),
		.o_digit  (o_digit),
		.o_effect (o_effect)
	);

endmodule

`default_nettype wire
